//--- mem_stage.f
+incdir+bench
src/mem_pkg.sv
src/store_unit.sv
src/data_ram.sv
src/load_unit.sv
src/mem_wb_reg.sv
src/mem_stage.sv
bench/mem_stage_tb.sv

//--- bench/mem_stage_tests.svh
function automatic logic [xlen-1:0] rand64();
	return {$urandom, $urandom};
endfunction

function automatic int access_size(input logic [2:0] f3);
	case (f3)
		f3_b, f3_bu: return 1;
		f3_h, f3_hu: return 2;
		f3_w, f3_wu: return 4;
		f3_d:        return 8;
		default:     return 0;
	endcase
endfunction

function automatic logic [ilen-1:0] make_load(input logic [2:0] f3, input logic [4:0] rd);
	return {12'd0, 5'd1, f3, rd, op_load};
endfunction

function automatic logic [ilen-1:0] make_store(input logic [2:0] f3);
	return {7'd0, 5'd2, 5'd1, f3, 5'd0, op_store};
endfunction

function automatic logic [ilen-1:0] make_alu(input logic [4:0] rd);
	return {7'd0, 5'd2, 5'd1, 3'b000, rd, 7'b011_0011};	// add
endfunction

// little-endian gather from the aligned lane, then extend
function automatic logic [xlen-1:0] expect_load(input logic [2:0] f3, input int off);
	int size;
	int base;
	logic [xlen-1:0] raw;
	size = access_size(f3);
	raw  = '0;
	if (size == 0)
		return raw;
	base = off - (off % size);
	for (int i = 0; i < size; i++)
		raw[8*i +: 8] = shadow[base + i];
	if ((f3 == f3_b || f3 == f3_h || f3 == f3_w) && raw[8*size-1])
		raw = raw | (~64'd0 << (8*size));
	return raw;
endfunction

task automatic do_store(input string name, input logic [2:0] f3, input int off,
		input logic [xlen-1:0] data);
	int size;
	size = access_size(f3);
	run_op(mem_base + off, make_store(f3), 1'b0, data);
	for (int i = 0; i < size; i++)
		shadow[off - (off % size) + i] = data[8*i +: 8];
	check({name, " fwd_reg_w_en"}, 0, fwd_wen_capture);
	check(name, mem_base + off, out_wb_data);	// stores write back the address
endtask

task automatic load_check(input string name, input logic [2:0] f3, input int off);
	logic [xlen-1:0] expected;
	expected = expect_load(f3, off);
	run_op(mem_base + off, make_load(f3, 5'd10), 1'b1, '0);
	check({name, " fwd"}, expected, fwd_capture);
	check(name, expected, out_wb_data);
endtask

task automatic test_reset();
	@(negedge clk);
	check("reset out_valid", 0, out_valid);
	check("reset out_reg_w_en", 0, out_reg_w_en);
	check("reset out_wb_data", 0, out_wb_data);
endtask

task automatic test_alu_pass();
	logic [xlen-1:0] alu_v;
	alu_v = rand64();
	run_op(alu_v, make_alu(5'd5), 1'b1, rand64());
	check("alu fwd_wb_data", alu_v, fwd_capture);
	check("alu fwd_rd", 5, fwd_rd_capture);
	check("alu fwd_reg_w_en", 1, fwd_wen_capture);
	check("alu out_wb_data", alu_v, out_wb_data);
	check("alu out_rd", 5, out_rd);
	check("alu out_pc", pc_next, out_pc);
	check("alu out_valid", 1, out_valid);
	check("alu out_reg_w_en", 1, out_reg_w_en);
	check("alu out_instr", make_alu(5'd5), out_instr);
endtask

task automatic test_store_widths();
	logic [2:0] widths [4];
	int size;
	widths = '{f3_b, f3_h, f3_w, f3_d};
	for (int dw = 0; dw < 8; dw++)
		do_store("store init", f3_d, dw * 8, rand64());
	for (int k = 0; k < 4; k++) begin
		size = access_size(widths[k]);
		for (int lane = 0; lane < 8; lane += size) begin
			do_store("store wb", widths[k], k * 8 + lane, rand64());
			load_check($sformatf("store f3=%0d lane=%0d", widths[k], lane), f3_d, k * 8);
		end
	end
endtask

task automatic test_load_ext();
	logic [2:0] kinds [7];
	int size;
	kinds = '{f3_b, f3_h, f3_w, f3_d, f3_bu, f3_hu, f3_wu};
	do_store("load pattern", f3_d, 40, 64'h8001_7fff_ff80_0080);	// sign bits both ways
	for (int k = 0; k < 7; k++) begin
		size = access_size(kinds[k]);
		for (int off = 32; off < 48; off += size)
			load_check($sformatf("load f3=%0d off=%0d", kinds[k], off), kinds[k], off);
	end
endtask

task automatic test_stall();
	logic [xlen-1:0] alu_v;
	alu_v   = rand64();
	pc_next = pc_next + 4;
	@(posedge clk);
	pc         <= pc_next;
	instr      <= make_alu(5'd7);
	reg_w_en   <= 1'b1;
	alu_result <= alu_v;
	in_valid   <= 1'b1;
	out_ready  <= 1'b1;
	@(posedge clk);
	out_ready  <= 1'b0;	// downstream stalls
	instr      <= make_store(f3_d);
	alu_result <= mem_base + 48;
	store_data <= ~expect_load(f3_d, 48);
	repeat (4) begin
		@(negedge clk);
		check("stall in_ready", 0, in_ready);
		check("stall out_valid", 1, out_valid);
		check("stall out_wb_data", alu_v, out_wb_data);
		check("stall out_pc", pc_next, out_pc);
		check("stall out_rd", 7, out_rd);
	end
	@(posedge clk);
	in_valid  <= 1'b0;
	out_ready <= 1'b1;
	load_check("stall ld", f3_d, 48);	// memory must be untouched
endtask

task automatic test_bubble();
	run_op(rand64(), make_alu(5'd3), 1'b1, '0);
	check("bubble before", 1, out_valid);
	@(posedge clk);
	@(negedge clk);
	check("bubble out_valid", 0, out_valid);
endtask

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
	import mem_pkg::*;
();

	localparam int              ram_depth_log2 = 10;
	localparam logic [xlen-1:0] mem_base = 64'h8000_0000;
	localparam int              timeout_cycles = 2000;

	logic            clk;
	logic            reset;
	logic [xlen-1:0] pc;
	logic [ilen-1:0] instr;
	logic            reg_w_en;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] store_data;
	logic            in_valid;
	logic            in_ready;
	logic            out_valid;
	logic [xlen-1:0] out_pc;
	logic [ilen-1:0] out_instr;
	logic            out_reg_w_en;
	logic [4:0]      out_rd;
	logic [xlen-1:0] out_wb_data;
	logic            out_ready;
	logic            fwd_reg_w_en;
	logic [4:0]      fwd_rd;
	logic [xlen-1:0] fwd_wb_data;

	logic [7:0]      shadow [0:63];	// bytes at mem_base and up
	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] fwd_capture;
	logic [4:0]      fwd_rd_capture;
	logic            fwd_wen_capture;
	int              errors;
	int              checks;
	int              cycles;

	mem_stage #(
		.ram_depth_log2 (ram_depth_log2),
		.mem_base       (mem_base)
	) uut (
		.clk (clk), .reset (reset), .pc (pc), .instr (instr),
		.reg_w_en (reg_w_en), .alu_result (alu_result), .store_data (store_data),
		.in_valid (in_valid), .in_ready (in_ready), .out_valid (out_valid),
		.out_pc (out_pc), .out_instr (out_instr), .out_reg_w_en (out_reg_w_en),
		.out_rd (out_rd), .out_wb_data (out_wb_data), .out_ready (out_ready),
		.fwd_reg_w_en (fwd_reg_w_en), .fwd_rd (fwd_rd), .fwd_wb_data (fwd_wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// one transfer, then out_* hold its result at the returning negedge
	task automatic run_op(input logic [xlen-1:0] alu_v, input logic [ilen-1:0] ins_v,
			input logic wen_v, input logic [xlen-1:0] data_v);
		pc_next = pc_next + 4;
		@(posedge clk);
		pc         <= pc_next;
		instr      <= ins_v;
		reg_w_en   <= wen_v;
		alu_result <= alu_v;
		store_data <= data_v;
		in_valid   <= 1'b1;
		out_ready  <= 1'b1;
		@(negedge clk);
		fwd_capture     = fwd_wb_data;
		fwd_rd_capture  = fwd_rd;
		fwd_wen_capture = fwd_reg_w_en;
		@(posedge clk);
		in_valid <= 1'b0;
		@(negedge clk);
	endtask

	`include "mem_stage_tests.svh"

	initial begin
		void'($urandom(32'h275279ef));
		errors     = 0;
		checks     = 0;
		pc_next    = 64'h0000_1000;
		reset      = 1'b1;
		pc         = '0;
		instr      = '0;
		reg_w_en   = 1'b0;
		alu_result = '0;
		store_data = '0;
		in_valid   = 1'b0;
		out_ready  = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_alu_pass();
		test_store_widths();
		test_load_ext();
		test_stall();
		test_bubble();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
	import mem_pkg::*;
#(
	parameter int              ram_depth_log2 = 10,
	parameter logic [xlen-1:0] mem_base = 64'h8000_0000
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [xlen-1:0] pc,
	input  logic [ilen-1:0] instr,
	input  logic            reg_w_en,
	input  logic [xlen-1:0] alu_result,
	input  logic [xlen-1:0] store_data,
	input  logic            in_valid,
	output logic            in_ready,
	output logic            out_valid,
	output logic [xlen-1:0] out_pc,
	output logic [ilen-1:0] out_instr,
	output logic            out_reg_w_en,
	output logic [4:0]      out_rd,
	output logic [xlen-1:0] out_wb_data,
	input  logic            out_ready,
	output logic            fwd_reg_w_en,
	output logic [4:0]      fwd_rd,
	output logic [xlen-1:0] fwd_wb_data
);

	instr_t            ins;
	logic              is_load;
	logic              is_store;
	logic [2:0]        acc_f3;
	logic              ram_we;
	logic [xlen-1:0]   ram_wdata;
	logic [xbytes-1:0] ram_wmask;
	logic [xlen-1:0]   ram_rdata;
	logic [xlen-1:0]   load_value;

	assign ins      = instr;
	assign is_load  = (ins.ld.opcode == op_load);
	assign is_store = (ins.st.opcode == op_store);
	assign acc_f3   = ins.st.funct3;	// same bits in both formats

	assign ram_we = is_store & in_valid & out_ready;	// write only on transfer

	store_unit u_store (
		.funct3     (acc_f3),
		.addr_low   (alu_result[2:0]),
		.store_data (store_data),
		.wdata      (ram_wdata),
		.wmask      (ram_wmask)
	);

	data_ram #(
		.ram_depth_log2 (ram_depth_log2),
		.mem_base       (mem_base)
	) u_ram (
		.clk   (clk),
		.addr  (alu_result),
		.rdata (ram_rdata),
		.we    (ram_we),
		.wdata (ram_wdata),
		.wmask (ram_wmask)
	);

	load_unit u_load (
		.funct3     (acc_f3),
		.addr_low   (alu_result[2:0]),
		.rdata      (ram_rdata),
		.load_value (load_value)
	);

	mem_wb_reg u_wb (
		.clk          (clk),
		.reset        (reset),
		.is_load      (is_load),
		.load_value   (load_value),
		.alu_result   (alu_result),
		.in_valid     (in_valid),
		.out_ready    (out_ready),
		.reg_w_en     (reg_w_en),
		.rd           (ins.ld.rd),
		.pc           (pc),
		.instr        (ins),
		.in_ready     (in_ready),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_instr    (out_instr),
		.out_reg_w_en (out_reg_w_en),
		.out_rd       (out_rd),
		.out_wb_data  (out_wb_data),
		.fwd_reg_w_en (fwd_reg_w_en),
		.fwd_rd       (fwd_rd),
		.fwd_wb_data  (fwd_wb_data)
	);

endmodule

//--- src/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg
	import mem_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            is_load,
	input  logic [xlen-1:0] load_value,
	input  logic [xlen-1:0] alu_result,
	input  logic            in_valid,
	input  logic            out_ready,
	input  logic            reg_w_en,
	input  logic [4:0]      rd,
	input  logic [xlen-1:0] pc,
	input  instr_t          instr,
	output logic            in_ready,
	output logic            out_valid,
	output logic [xlen-1:0] out_pc,
	output instr_t          out_instr,
	output logic            out_reg_w_en,
	output logic [4:0]      out_rd,
	output logic [xlen-1:0] out_wb_data,
	output logic            fwd_reg_w_en,
	output logic [4:0]      fwd_rd,
	output logic [xlen-1:0] fwd_wb_data
);

	logic [xlen-1:0] wb_data;

	// stores fall on the alu side
	assign wb_data = is_load ? load_value : alu_result;

	assign in_ready = out_ready;	// no buffering here

	// bypass toward earlier stages
	assign fwd_reg_w_en = reg_w_en;
	assign fwd_rd       = rd;
	assign fwd_wb_data  = wb_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			out_pc       <= '0;
			out_instr    <= '0;
			out_reg_w_en <= 1'b0;
			out_rd       <= 5'd0;
			out_wb_data  <= '0;
		end else if (out_ready) begin
			out_valid    <= in_valid;	// bubble when in_valid low
			out_pc       <= pc;
			out_instr    <= instr;
			out_reg_w_en <= reg_w_en;
			out_rd       <= rd;
			out_wb_data  <= wb_data;
		end
	end

endmodule

//--- src/load_unit.sv
`timescale 1ns/1ps

module load_unit
	import mem_pkg::*;
(
	input  logic [2:0]      funct3,
	input  logic [2:0]      addr_low,
	input  logic [xlen-1:0] rdata,
	output logic [xlen-1:0] load_value
);

	logic [2:0]      lane;
	logic [5:0]      shamt;
	logic [xlen-1:0] shifted;

	// lane per access size, low address bits below the size dropped
	always_comb begin
		case (funct3)
			f3_b, f3_bu: lane = addr_low;
			f3_h, f3_hu: lane = {addr_low[2:1], 1'b0};
			f3_w, f3_wu: lane = {addr_low[2], 2'b00};
			default:     lane = 3'd0;
		endcase
	end

	assign shamt   = {lane, 3'b000};
	assign shifted = rdata >> shamt;	// addressed lane now at bit 0

	always_comb begin
		case (funct3)
			f3_b: begin
				load_value = {{56{shifted[7]}}, shifted[7:0]};
			end
			f3_h: begin
				load_value = {{48{shifted[15]}}, shifted[15:0]};
			end
			f3_w: begin
				load_value = {{32{shifted[31]}}, shifted[31:0]};
			end
			f3_d: begin
				load_value = rdata;
			end
			f3_bu: begin
				load_value = {56'd0, shifted[7:0]};
			end
			f3_hu: begin
				load_value = {48'd0, shifted[15:0]};
			end
			f3_wu: begin
				load_value = {32'd0, shifted[31:0]};
			end
			default: begin
				load_value = '0;
			end
		endcase
	end

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram
	import mem_pkg::*;
#(
	parameter int              ram_depth_log2 = 10,
	parameter logic [xlen-1:0] mem_base = 64'h8000_0000
) (
	input  logic              clk,
	input  logic [xlen-1:0]   addr,
	output logic [xlen-1:0]   rdata,
	input  logic              we,
	input  logic [xlen-1:0]   wdata,
	input  logic [xbytes-1:0] wmask
);

	localparam int depth = 2 ** ram_depth_log2;

	logic [xlen-1:0] mem [0:depth-1];
	logic [xlen-1:0] offset;
	logic [ram_depth_log2-1:0] idx;

	// doubleword index, wraps at depth
	assign offset = addr - mem_base;
	assign idx    = offset[ram_depth_log2+2:3];

	assign rdata = mem[idx];	// async read

	always_ff @(posedge clk) begin
		if (we) begin
			for (int i = 0; i < xbytes; i++) begin
				if (wmask[i]) begin
					mem[idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

endmodule

//--- src/store_unit.sv
`timescale 1ns/1ps

module store_unit
	import mem_pkg::*;
(
	input  logic [2:0]        funct3,
	input  logic [2:0]        addr_low,
	input  logic [xlen-1:0]   store_data,
	output logic [xlen-1:0]   wdata,
	output logic [xbytes-1:0] wmask
);

	logic [2:0]      lane;
	logic [5:0]      shamt;
	logic [xlen-1:0] payload;
	logic [xbytes-1:0] base_mask;

	// lane aligned down to the access size
	always_comb begin
		lane      = 3'd0;
		payload   = '0;
		base_mask = '0;
		case (funct3)
			f3_b: begin
				lane      = addr_low;
				payload   = {56'd0, store_data[7:0]};
				base_mask = 8'h01;
			end
			f3_h: begin
				lane      = {addr_low[2:1], 1'b0};	// bit 0 ignored
				payload   = {48'd0, store_data[15:0]};
				base_mask = 8'h03;
			end
			f3_w: begin
				lane      = {addr_low[2], 2'b00};
				payload   = {32'd0, store_data[31:0]};
				base_mask = 8'h0f;
			end
			f3_d: begin
				payload   = store_data;
				base_mask = 8'hff;
			end
			default: begin
				base_mask = '0;	// not a valid store width
			end
		endcase
	end

	assign shamt = {lane, 3'b000};
	assign wdata = payload << shamt;
	assign wmask = base_mask << lane;

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

	localparam int xlen = 64;
	localparam int ilen = 32;
	localparam int xbytes = xlen / 8;	// byte lanes per doubleword

	localparam logic [6:0] op_load  = 7'b000_0011;
	localparam logic [6:0] op_store = 7'b010_0011;

	// access widths, shared by loads and stores
	localparam logic [2:0] f3_b  = 3'b000;
	localparam logic [2:0] f3_h  = 3'b001;
	localparam logic [2:0] f3_w  = 3'b010;
	localparam logic [2:0] f3_d  = 3'b011;
	localparam logic [2:0] f3_bu = 3'b100;	// unsigned loads only
	localparam logic [2:0] f3_hu = 3'b101;
	localparam logic [2:0] f3_wu = 3'b110;

	// I-format, as used by loads
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} load_fields_t;

	// S-format, as used by stores
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;	// sits where rd would be
		logic [6:0] opcode;
	} store_fields_t;

	typedef union packed {
		load_fields_t  ld;
		store_fields_t st;
	} instr_t;

endpackage
